//--- mchan_lite.f
design/mchan_pkg.sv
design/mchan_cmd_unpack.sv
design/mchan_trans_queue.sv
design/mchan_burst_split.sv
design/mchan_ctrl_top.sv
tests/tb_clk_gen.sv
tests/tb_checker.sv
tests/tb_mchan_ctrl.sv

//--- tests/tb_mchan_ctrl.sv
// ==================================================
// Testbench top: runs the command table through the
// DMA front end and drives random burst grants
// ==================================================
module tb_mchan_ctrl
   import mchan_pkg::*;
();

   localparam int N_CMDS     = 11;
   localparam int NAME_W     = 8 * 8;  // Eight characters per name
   localparam int RST_CYCLES = 10;
   localparam int SLACK      = 8;

   typedef enum int {GNT_RAND, GNT_RX_HOLD, GNT_HOLD} gnt_mode_e;

   logic                 clk;
   logic                 rst_n;
   logic                 cmd_req;
   logic [CMD_WIDTH-1:0] cmd_dat;
   logic                 cmd_gnt;
   logic                 tx_burst_req;
   burst_t               tx_burst;
   logic                 tx_burst_gnt;
   logic                 rx_burst_req;
   burst_t               rx_burst;
   logic                 rx_burst_gnt;
   logic [NAME_W-1:0]    cur_name;
   logic                 end_run;
   int                   tx_pending;
   int                   rx_pending;
   int                   mismatch_cnt;
   int                   fail_cnt;

   // Command table
   logic [NAME_W-1:0]         tab_name [N_CMDS];
   opc_e                      tab_opc  [N_CMDS];
   logic [LEN_WIDTH-1:0]      tab_len  [N_CMDS];
   logic [TCDM_ADD_WIDTH-1:0] tab_tcdm [N_CMDS];
   logic [EXT_ADD_WIDTH-1:0]  tab_ext  [N_CMDS];
   gnt_mode_e                 tab_mode [N_CMDS];

   gnt_mode_e   gnt_mode;
   integer      seed;
   logic [31:0] rnd;
   int          n_tab;
   int          cycle_cnt = 0;
   int          cycle_limit;

   tb_clk_gen #(.RST_CYCLES(RST_CYCLES)) i_clk_gen (.clk_o(clk), .rst_no(rst_n));

   mchan_ctrl_top DUT
   (
      .clk_i          ( clk          ),
      .rst_ni         ( rst_n        ),
      .cmd_req_i      ( cmd_req      ),
      .cmd_dat_i      ( cmd_dat      ),
      .cmd_gnt_o      ( cmd_gnt      ),
      .tx_burst_req_o ( tx_burst_req ),
      .tx_burst_o     ( tx_burst     ),
      .tx_burst_gnt_i ( tx_burst_gnt ),
      .rx_burst_req_o ( rx_burst_req ),
      .rx_burst_o     ( rx_burst     ),
      .rx_burst_gnt_i ( rx_burst_gnt )
   );

   tb_checker #(.NAME_W(NAME_W)) i_checker
   (
      .clk_i          ( clk          ),
      .rst_ni         ( rst_n        ),
      .name_i         ( cur_name     ),
      .cmd_req_i      ( cmd_req      ),
      .cmd_dat_i      ( cmd_dat      ),
      .cmd_gnt_i      ( cmd_gnt      ),
      .tx_burst_req_i ( tx_burst_req ),
      .tx_burst_i     ( tx_burst     ),
      .tx_burst_gnt_i ( tx_burst_gnt ),
      .rx_burst_req_i ( rx_burst_req ),
      .rx_burst_i     ( rx_burst     ),
      .rx_burst_gnt_i ( rx_burst_gnt ),
      .end_i          ( end_run      ),
      .tx_pending_o   ( tx_pending   ),
      .rx_pending_o   ( rx_pending   ),
      .mismatch_cnt_o ( mismatch_cnt ),
      .fail_cnt_o     ( fail_cnt     )
   );

   task automatic add_cmd(input logic [NAME_W-1:0] name, input opc_e opc,
                          input logic [LEN_WIDTH-1:0] len, input logic [TCDM_ADD_WIDTH-1:0] tcdm,
                          input logic [EXT_ADD_WIDTH-1:0] ext, input gnt_mode_e mode);
      tab_name[n_tab] = name;
      tab_opc[n_tab]  = opc;
      tab_len[n_tab]  = len;
      tab_tcdm[n_tab] = tcdm;
      tab_ext[n_tab]  = ext;
      tab_mode[n_tab] = mode;
      n_tab++;
   endtask

   // Present one word and hold it until the grant is seen
   task automatic send_word(input logic [CMD_WIDTH-1:0] word);
      int stall;
      stall = 0;
      @(negedge clk);
      cmd_req = 1'b1;
      cmd_dat = word;
      while (!cmd_gnt)
      begin
         @(negedge clk);
         stall++;
         if (stall > 8)
            gnt_mode <= GNT_RAND;  // Buffer full so let bursts drain
      end
   endtask

   task automatic send_cmd(input int i);
      send_word({15'd0, tab_opc[i], tab_len[i]});
      send_word({16'd0, tab_tcdm[i]});
      send_word(tab_ext[i]);
      @(negedge clk);
      cmd_req = 1'b0;
   endtask

   task automatic wait_idle(input logic both);
      while (tx_pending != 0 || (both && rx_pending != 0))
         @(negedge clk);
   endtask

   always @(negedge clk)
   begin
      rnd          = $random(seed);
      tx_burst_gnt = (gnt_mode != GNT_HOLD) && rnd[0];
      rx_burst_gnt = (gnt_mode == GNT_RAND) && rnd[1];
   end

   always @(posedge clk)
   begin
      cycle_cnt++;
      if (cycle_cnt >= cycle_limit)
      begin
         $display("Timeout after %0d cycles with %0d TX and %0d RX bursts still expected",
                  cycle_cnt, tx_pending, rx_pending);
         $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
         $display(">>> FAIL");
         $finish;
      end
   end

   initial
   begin
      cmd_req      = 1'b0;
      cmd_dat      = '0;
      tx_burst_gnt = 1'b0;
      rx_burst_gnt = 1'b0;
      cur_name     = '0;
      end_run      = 1'b0;
      gnt_mode     = GNT_RAND;
      seed         = 9132;
      n_tab        = 0;
      add_cmd("rx_stall", OPC_RX, 16'd150, 16'h0200, 32'h1000_0000, GNT_RX_HOLD);
      add_cmd("tx_pass ", OPC_TX, 16'd200, 16'h0400, 32'h2000_0010, GNT_RX_HOLD);
      add_cmd("tx_fill0", OPC_TX, 16'd130, 16'h0800, 32'h3000_0000, GNT_HOLD);
      add_cmd("rx_fill1", OPC_RX, 16'd10,  16'h0900, 32'h3000_1000, GNT_HOLD);
      add_cmd("tx_fill2", OPC_TX, 16'd64,  16'h0a00, 32'h3000_2000, GNT_HOLD);
      add_cmd("rx_fill3", OPC_RX, 16'd100, 16'h0b00, 32'h3000_3000, GNT_HOLD);
      add_cmd("tx_fill4", OPC_TX, 16'd1,   16'h0c00, 32'h3000_4000, GNT_HOLD);
      add_cmd("rx_fill5", OPC_RX, 16'd65,  16'h0d00, 32'h3000_5000, GNT_HOLD);
      add_cmd("tx_wait6", OPC_TX, 16'd90,  16'h0e00, 32'h3000_6000, GNT_HOLD);
      add_cmd("rx_short", OPC_RX, 16'd33,  16'h0f00, 32'h4000_0000, GNT_RAND);
      add_cmd("tx_long ", OPC_TX, 16'd256, 16'hff00, 32'h4000_1000, GNT_RAND);
      cycle_limit = RST_CYCLES;
      for (int i = 0; i < N_CMDS; i++)
         cycle_limit += (3 + (int'(tab_len[i]) + BURST_MAX_LEN - 1) / BURST_MAX_LEN) * SLACK;

      @(posedge rst_n);
      for (int i = 0; i < N_CMDS; i++)
      begin
         gnt_mode <= tab_mode[i];
         cur_name = tab_name[i];
         send_cmd(i);
         // TX behind a stalled RX transfer has to finish on its own
         if (tab_mode[i] == GNT_RX_HOLD && tab_opc[i] == OPC_TX)
            wait_idle(1'b0);
      end
      gnt_mode <= GNT_RAND;
      wait_idle(1'b1);
      repeat (8) @(negedge clk);  // Room for late or doubled bursts
      end_run = 1'b1;
      repeat (2) @(negedge clk);
      $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
      if (mismatch_cnt == 0 && fail_cnt == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

//--- tests/tb_checker.sv
// ==================================================
// Testbench checker: builds the expected bursts from
// accepted command words and compares both ports
// ==================================================
module tb_checker
   import mchan_pkg::*;
#(
   parameter int NAME_W = 64
)
(
   input  logic                 clk_i,
   input  logic                 rst_ni,
   input  logic [NAME_W-1:0]    name_i,
   input  logic                 cmd_req_i,
   input  logic [CMD_WIDTH-1:0] cmd_dat_i,
   input  logic                 cmd_gnt_i,
   input  logic                 tx_burst_req_i,
   input  burst_t               tx_burst_i,
   input  logic                 tx_burst_gnt_i,
   input  logic                 rx_burst_req_i,
   input  burst_t               rx_burst_i,
   input  logic                 rx_burst_gnt_i,
   input  logic                 end_i,
   output int                   tx_pending_o,
   output int                   rx_pending_o,
   output int                   mismatch_cnt_o,
   output int                   fail_cnt_o
);

   burst_t               exp_tx_q [$];
   burst_t               exp_rx_q [$];
   logic [NAME_W-1:0]    name_tx_q [$];
   logic [NAME_W-1:0]    name_rx_q [$];
   logic [NAME_W-1:0]    cmd_name;
   logic [CMD_WIDTH-1:0] word0;
   logic [CMD_WIDTH-1:0] word1;
   int                   word_idx = 0;
   int                   outstanding = 0;  // Transfers inside the DUT
   int                   prev_queued = 0;
   logic                 prev_stall = 1'b0;
   logic                 prev_busy = 1'b0;  // Both splitters active
   logic                 full_seen = 1'b0;
   logic                 reset_checked = 1'b0;
   logic                 ended = 1'b0;

   initial
   begin
      tx_pending_o   = 0;
      rx_pending_o   = 0;
      mismatch_cnt_o = 0;
      fail_cnt_o     = 0;
   end

   // Cut one transfer into bursts of at most BURST_MAX_LEN bytes
   task automatic add_expected(input logic [CMD_WIDTH-1:0] w0, input logic [CMD_WIDTH-1:0] w1,
                               input logic [CMD_WIDTH-1:0] w2, input logic [NAME_W-1:0] name);
      burst_t b;
      int     rem;
      int     blen;
      rem        = int'(w0[LEN_WIDTH-1:0]);
      b.tcdm_add = w1[TCDM_ADD_WIDTH-1:0];
      b.ext_add  = w2;
      while (rem > 0)
      begin
         blen   = (rem > BURST_MAX_LEN) ? BURST_MAX_LEN : rem;
         b.len  = BURST_LEN_WIDTH'(blen);
         b.last = (rem <= BURST_MAX_LEN);
         if (w0[LEN_WIDTH])  // Opcode bit, set for RX
         begin
            exp_rx_q.push_back(b);
            name_rx_q.push_back(name);
         end
         else
         begin
            exp_tx_q.push_back(b);
            name_tx_q.push_back(name);
         end
         b.tcdm_add = b.tcdm_add + TCDM_ADD_WIDTH'(blen);
         b.ext_add  = b.ext_add + EXT_ADD_WIDTH'(blen);
         rem        = rem - blen;
      end
   endtask

   task automatic take_word();
      if (word_idx == 0)
      begin
         word0    = cmd_dat_i;
         cmd_name = name_i;
      end
      else if (word_idx == 1)
      begin
         word1 = cmd_dat_i;
      end
      else
      begin
         add_expected(word0, word1, cmd_dat_i, cmd_name);
         outstanding++;
      end
      word_idx = (word_idx == 2) ? 0 : word_idx + 1;
   endtask

   task automatic compare_burst(input logic is_rx, input burst_t act);
      burst_t            exp;
      logic [NAME_W-1:0] name;
      if ((is_rx ? exp_rx_q.size() : exp_tx_q.size()) == 0)
      begin
         fail_cnt_o++;
         $display("Unexpected %s burst accepted with no transfer pending", is_rx ? "RX" : "TX");
         return;
      end
      if (is_rx)
      begin
         exp  = exp_rx_q.pop_front();
         name = name_rx_q.pop_front();
      end
      else
      begin
         exp  = exp_tx_q.pop_front();
         name = name_tx_q.pop_front();
      end
      if (act.last)
         outstanding--;
      if (act !== exp)
      begin
         mismatch_cnt_o++;
         $write("MISMATCH %s: expected tcdm=%h ext=%h len=%0d last=%b", name,
                exp.tcdm_add, exp.ext_add, exp.len, exp.last);
         $display(", actual tcdm=%h ext=%h len=%0d last=%b",
                  act.tcdm_add, act.ext_add, act.len, act.last);
      end
   endtask

   // A grant low for two cycles in a row means the push was refused
   task automatic check_backpressure();
      int queued;
      queued = outstanding - int'(tx_burst_req_i) - int'(rx_burst_req_i) - int'(!cmd_gnt_i);
      if (prev_stall && !cmd_gnt_i)
      begin
         if (prev_queued != TRANS_QUEUE_DEPTH)
         begin
            fail_cnt_o++;
            $display("Command port stalled with only %0d transfers queued", prev_queued);
         end
         else if (prev_busy)
            full_seen = 1'b1;
      end
      prev_stall  = !cmd_gnt_i;
      prev_queued = queued;
      prev_busy   = tx_burst_req_i && rx_burst_req_i;
   endtask

   task automatic report_missing();
      ended = 1'b1;
      for (int k = 0; k < exp_tx_q.size(); k++)
      begin
         fail_cnt_o++;
         $display("Missing TX burst of %s at TCDM address %h",
                  name_tx_q[k], exp_tx_q[k].tcdm_add);
      end
      for (int k = 0; k < exp_rx_q.size(); k++)
      begin
         fail_cnt_o++;
         $display("Missing RX burst of %s at TCDM address %h",
                  name_rx_q[k], exp_rx_q[k].tcdm_add);
      end
      if (!full_seen)
      begin
         fail_cnt_o++;
         $display("Command port never stalled on a full buffer with both splitters busy");
      end
   endtask

   always @(posedge clk_i)
   begin
      if (rst_ni)
      begin
         if (!reset_checked)
         begin
            reset_checked = 1'b1;
            if (!cmd_gnt_i || tx_burst_req_i || rx_burst_req_i)
            begin
               mismatch_cnt_o++;
               $write("MISMATCH reset: expected gnt=1 tx_req=0 rx_req=0");
               $display(", actual gnt=%b tx_req=%b rx_req=%b",
                        cmd_gnt_i, tx_burst_req_i, rx_burst_req_i);
            end
         end
         check_backpressure();
         if (cmd_req_i && cmd_gnt_i)
            take_word();
         if (tx_burst_req_i && tx_burst_gnt_i)
            compare_burst(1'b0, tx_burst_i);
         if (rx_burst_req_i && rx_burst_gnt_i)
            compare_burst(1'b1, rx_burst_i);
         if (end_i && !ended)
            report_missing();
         tx_pending_o = exp_tx_q.size();
         rx_pending_o = exp_rx_q.size();
      end
   end

endmodule

//--- tests/tb_clk_gen.sv
// ==================================================
// Testbench clock and reset source
// ==================================================
module tb_clk_gen
#(
   parameter int RST_CYCLES = 10
)
(
   output logic clk_o,
   output logic rst_no
);

   initial
   begin
      clk_o  = 1'b0;
      rst_no = 1'b0;
      repeat (RST_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      rst_no = 1'b1;  // Released between active edges
   end

   always #5 clk_o = ~clk_o;

endmodule

//--- design/mchan_ctrl_top.sv
// ==================================================
// DMA command front end: unpacker, shared queue
// and one burst splitter per direction
// ==================================================
module mchan_ctrl_top
   import mchan_pkg::*;
(
   input  logic                 clk_i,
   input  logic                 rst_ni,

   input  logic                 cmd_req_i,
   input  logic [CMD_WIDTH-1:0] cmd_dat_i,
   output logic                 cmd_gnt_o,

   output logic                 tx_burst_req_o,
   output burst_t               tx_burst_o,
   input  logic                 tx_burst_gnt_i,

   output logic                 rx_burst_req_o,
   output burst_t               rx_burst_o,
   input  logic                 rx_burst_gnt_i
);

   // Unpacker to queue
   logic   trans_req;
   logic   trans_gnt;
   trans_t trans;

   // Queue to splitters
   logic   tx_trans_req;
   logic   tx_trans_gnt;
   trans_t tx_trans;
   logic   rx_trans_req;
   logic   rx_trans_gnt;
   trans_t rx_trans;

   mchan_cmd_unpack i_cmd_unpack
   (
      .clk_i       ( clk_i     ),
      .rst_ni      ( rst_ni    ),
      .cmd_req_i   ( cmd_req_i ),
      .cmd_dat_i   ( cmd_dat_i ),
      .cmd_gnt_o   ( cmd_gnt_o ),
      .trans_req_o ( trans_req ),
      .trans_o     ( trans     ),
      .trans_gnt_i ( trans_gnt )
   );

   mchan_trans_queue #(
      .DEPTH ( TRANS_QUEUE_DEPTH )
   ) i_trans_queue
   (
      .clk_i    ( clk_i        ),
      .rst_ni   ( rst_ni       ),
      .req_i    ( trans_req    ),
      .gnt_o    ( trans_gnt    ),
      .dat_i    ( trans        ),
      .tx_req_o ( tx_trans_req ),
      .tx_gnt_i ( tx_trans_gnt ),
      .tx_dat_o ( tx_trans     ),
      .rx_req_o ( rx_trans_req ),
      .rx_gnt_i ( rx_trans_gnt ),
      .rx_dat_o ( rx_trans     )
   );

   mchan_burst_split i_tx_split
   (
      .clk_i       ( clk_i          ),
      .rst_ni      ( rst_ni         ),
      .trans_req_i ( tx_trans_req   ),
      .trans_i     ( tx_trans       ),
      .trans_gnt_o ( tx_trans_gnt   ),
      .burst_req_o ( tx_burst_req_o ),
      .burst_o     ( tx_burst_o     ),
      .burst_gnt_i ( tx_burst_gnt_i )
   );

   mchan_burst_split i_rx_split
   (
      .clk_i       ( clk_i          ),
      .rst_ni      ( rst_ni         ),
      .trans_req_i ( rx_trans_req   ),
      .trans_i     ( rx_trans       ),
      .trans_gnt_o ( rx_trans_gnt   ),
      .burst_req_o ( rx_burst_req_o ),
      .burst_o     ( rx_burst_o     ),
      .burst_gnt_i ( rx_burst_gnt_i )
   );

endmodule

//--- design/mchan_burst_split.sv
// ==================================================
// Burst splitter: takes one transaction at a time
// and issues bursts no longer than the burst limit
// ==================================================
module mchan_burst_split
   import mchan_pkg::*;
(
   input  logic   clk_i,
   input  logic   rst_ni,

   // From the transaction queue
   input  logic   trans_req_i,
   input  trans_t trans_i,
   output logic   trans_gnt_o,

   // Burst output
   output logic   burst_req_o,
   output burst_t burst_o,
   input  logic   burst_gnt_i
);

   logic                       active_q;  // Transaction in progress
   logic [TCDM_ADD_WIDTH-1:0]  tcdm_add_q;
   logic [EXT_ADD_WIDTH-1:0]   ext_add_q;
   logic [LEN_WIDTH-1:0]       rem_len_q;  // Bytes still to issue
   logic                       trans_take;
   logic                       burst_take;
   logic                       last;
   logic [BURST_LEN_WIDTH-1:0] cur_len;

   assign trans_gnt_o = ~active_q;
   assign trans_take  = trans_req_i & trans_gnt_o;
   assign burst_take  = burst_req_o & burst_gnt_i;

   // Remaining bytes fit in one burst
   assign last = (rem_len_q <= LEN_WIDTH'(BURST_MAX_LEN));

   always_comb
   begin
      if (last)
         cur_len = rem_len_q[BURST_LEN_WIDTH-1:0];
      else
         cur_len = BURST_LEN_WIDTH'(BURST_MAX_LEN);
   end

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         active_q <= 1'b0;
      end
      else
      begin
         if (trans_take)
            active_q <= 1'b1;
         else if (burst_take && last)
            active_q <= 1'b0;  // Idle right after the final burst
      end
   end

   // Address and length bookkeeping
   always_ff @(posedge clk_i)
   begin
      if (trans_take)
      begin
         tcdm_add_q <= trans_i.tcdm_add;
         ext_add_q  <= trans_i.ext_add;
         rem_len_q  <= trans_i.len;
      end
      else if (burst_take)
      begin
         tcdm_add_q <= tcdm_add_q + TCDM_ADD_WIDTH'(cur_len);
         ext_add_q  <= ext_add_q + EXT_ADD_WIDTH'(cur_len);
         rem_len_q  <= rem_len_q - LEN_WIDTH'(cur_len);
      end
   end

   assign burst_req_o      = active_q;
   assign burst_o.tcdm_add = tcdm_add_q;
   assign burst_o.ext_add  = ext_add_q;
   assign burst_o.len      = cur_len;
   assign burst_o.last     = last;

endmodule

//--- design/mchan_trans_queue.sv
// ==================================================
// Transaction queue: one shared slot buffer with
// separate TX and RX order tables and output ports
// ==================================================
module mchan_trans_queue
   import mchan_pkg::*;
#(
   parameter int DEPTH = TRANS_QUEUE_DEPTH
)
(
   input  logic   clk_i,
   input  logic   rst_ni,

   // Push side
   input  logic   req_i,
   output logic   gnt_o,
   input  trans_t dat_i,

   // TX pop side
   output logic   tx_req_o,
   input  logic   tx_gnt_i,
   output trans_t tx_dat_o,

   // RX pop side
   output logic   rx_req_o,
   input  logic   rx_gnt_i,
   output trans_t rx_dat_o
);

   localparam int IDX_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   trans_t                      buffer_q [DEPTH];
   logic [DEPTH-1:0]            busy_q;
   logic [DEPTH-1:0][IDX_W-1:0] tx_table_q;  // Slot indices in TX order
   logic [DEPTH-1:0][IDX_W-1:0] rx_table_q;  // Slot indices in RX order
   logic [IDX_W-1:0]            tx_wr_q;
   logic [IDX_W-1:0]            tx_rd_q;
   logic [IDX_W-1:0]            rx_wr_q;
   logic [IDX_W-1:0]            rx_rd_q;
   logic [CNT_W-1:0]            cnt_q;
   logic [CNT_W-1:0]            tx_cnt_q;
   logic [CNT_W-1:0]            rx_cnt_q;
   logic [IDX_W-1:0]            free_idx;
   logic                        full;
   logic                        push;
   logic                        push_tx;
   logic                        push_rx;
   logic                        pop_tx;
   logic                        pop_rx;

   // Table pointer step with wrap at DEPTH
   function automatic logic [IDX_W-1:0] next_ptr(input logic [IDX_W-1:0] ptr);
      if (ptr == IDX_W'(DEPTH - 1))
         return '0;
      return ptr + 1'b1;
   endfunction

   assign full    = (cnt_q == CNT_W'(DEPTH));
   assign push    = req_i & ~full;
   assign push_tx = push & (dat_i.opc == OPC_TX);
   assign push_rx = push & (dat_i.opc == OPC_RX);
   assign pop_tx  = tx_req_o & tx_gnt_i;
   assign pop_rx  = rx_req_o & rx_gnt_i;

   // Lowest free slot, the last hit in a downward scan wins
   always_comb
   begin
      free_idx = '0;
      for (int i = DEPTH - 1; i >= 0; i--)
      begin
         if (!busy_q[i])
            free_idx = IDX_W'(i);
      end
   end

   // Element counts, any mix of push and pops in one cycle
   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         cnt_q    <= '0;
         tx_cnt_q <= '0;
         rx_cnt_q <= '0;
      end
      else
      begin
         cnt_q    <= cnt_q + CNT_W'(push) - CNT_W'(pop_tx) - CNT_W'(pop_rx);
         tx_cnt_q <= tx_cnt_q + CNT_W'(push_tx) - CNT_W'(pop_tx);
         rx_cnt_q <= rx_cnt_q + CNT_W'(push_rx) - CNT_W'(pop_rx);
      end
   end

   // Busy tags and table pointers
   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         busy_q  <= '0;
         tx_wr_q <= '0;
         tx_rd_q <= '0;
         rx_wr_q <= '0;
         rx_rd_q <= '0;
      end
      else
      begin
         if (push)
            busy_q[free_idx] <= 1'b1;
         if (push_tx)
            tx_wr_q <= next_ptr(tx_wr_q);
         if (push_rx)
            rx_wr_q <= next_ptr(rx_wr_q);

         // A popped slot is never the one being filled
         if (pop_tx)
         begin
            busy_q[tx_table_q[tx_rd_q]] <= 1'b0;
            tx_rd_q                     <= next_ptr(tx_rd_q);
         end
         if (pop_rx)
         begin
            busy_q[rx_table_q[rx_rd_q]] <= 1'b0;
            rx_rd_q                     <= next_ptr(rx_rd_q);
         end
      end
   end

   // Slot contents and order tables
   always_ff @(posedge clk_i)
   begin
      if (push)
         buffer_q[free_idx] <= dat_i;
      if (push_tx)
         tx_table_q[tx_wr_q] <= free_idx;
      if (push_rx)
         rx_table_q[rx_wr_q] <= free_idx;
   end

   assign tx_dat_o = buffer_q[tx_table_q[tx_rd_q]];
   assign rx_dat_o = buffer_q[rx_table_q[rx_rd_q]];
   assign tx_req_o = (tx_cnt_q != '0);
   assign rx_req_o = (rx_cnt_q != '0);
   assign gnt_o    = ~full;

endmodule

//--- design/mchan_cmd_unpack.sv
// ==================================================
// Command unpacker: gathers three command words
// into one transaction and offers it to the queue
// ==================================================
module mchan_cmd_unpack
   import mchan_pkg::*;
(
   input  logic                 clk_i,
   input  logic                 rst_ni,

   // Command word port
   input  logic                 cmd_req_i,
   input  logic [CMD_WIDTH-1:0] cmd_dat_i,
   output logic                 cmd_gnt_o,

   // Towards the transaction queue
   output logic                 trans_req_o,
   output trans_t               trans_o,
   input  logic                 trans_gnt_i
);

   logic [1:0] word_cnt_q;   // Index of the next expected word
   logic       trans_req_q;
   trans_t     trans_q;
   logic       cmd_take;
   logic       trans_push;

   // Collecting as long as nothing waits for the queue
   assign cmd_gnt_o  = ~trans_req_q;
   assign cmd_take   = cmd_req_i & cmd_gnt_o;
   assign trans_push = trans_req_q & trans_gnt_i;

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         word_cnt_q  <= 2'd0;
         trans_req_q <= 1'b0;
      end
      else
      begin
         if (trans_push)
            trans_req_q <= 1'b0;

         if (cmd_take)
         begin
            if (word_cnt_q == 2'd2)
            begin
               word_cnt_q  <= 2'd0;
               trans_req_q <= 1'b1;  // Complete transaction
            end
            else
            begin
               word_cnt_q <= word_cnt_q + 2'd1;
            end
         end
      end
   end

   // Field capture per word
   always_ff @(posedge clk_i)
   begin
      if (cmd_take)
      begin
         case (word_cnt_q)
            2'd0:
            begin
               trans_q.len <= cmd_dat_i[LEN_WIDTH-1:0];
               trans_q.opc <= opc_e'(cmd_dat_i[LEN_WIDTH]);  // Bit right above length
            end
            2'd1:
               trans_q.tcdm_add <= cmd_dat_i[TCDM_ADD_WIDTH-1:0];
            default:
               trans_q.ext_add <= cmd_dat_i[EXT_ADD_WIDTH-1:0];
         endcase
      end
   end

   assign trans_req_o = trans_req_q;
   assign trans_o     = trans_q;

endmodule

//--- design/mchan_pkg.sv
// ==================================================
// Shared widths, limits and types of the DMA
// command front end: opcodes, transactions, bursts
// ==================================================
package mchan_pkg;

   // Field widths
   localparam int CMD_WIDTH      = 32;
   localparam int LEN_WIDTH      = 16;  // Transfer length in bytes
   localparam int TCDM_ADD_WIDTH = 16;
   localparam int EXT_ADD_WIDTH  = 32;

   // Slots shared by TX and RX
   localparam int TRANS_QUEUE_DEPTH = 4;

   // Largest burst in bytes and the width that holds it
   localparam int BURST_MAX_LEN   = 64;
   localparam int BURST_LEN_WIDTH = $clog2(BURST_MAX_LEN + 1);

   typedef enum logic
   {
      OPC_TX = 1'b0,
      OPC_RX = 1'b1
   } opc_e;

   // Opcode sits directly above ext address, tcdm address and length
   typedef struct packed
   {
      opc_e                      opc;
      logic [EXT_ADD_WIDTH-1:0]  ext_add;
      logic [TCDM_ADD_WIDTH-1:0] tcdm_add;
      logic [LEN_WIDTH-1:0]      len;
   } trans_t;

   typedef struct packed
   {
      logic [TCDM_ADD_WIDTH-1:0]  tcdm_add;
      logic [EXT_ADD_WIDTH-1:0]   ext_add;
      logic [BURST_LEN_WIDTH-1:0] len;
      logic                       last;  // Final burst of its transaction
   } burst_t;

endpackage
